//--- source/jackal_defines.svh
`ifndef JACKAL_DEFINES_SVH
`define JACKAL_DEFINES_SVH

// ====================
// PS/2 set 2 make codes
// ====================
`define KEY_1      8'h16
`define KEY_2      8'h1E
`define KEY_5      8'h2E
`define KEY_6      8'h36
`define KEY_9      8'h46
`define KEY_P      8'h4D
// Arrow keys, extended codes
`define KEY_UP     8'h75
`define KEY_DOWN   8'h72
`define KEY_LEFT   8'h6B
`define KEY_RIGHT  8'h74
// Fire buttons
`define KEY_CTRL   8'h14
`define KEY_ALT    8'h11

// ====================
// ROM download map
// ====================
// Four 64 KiB regions in loader address space
`define ROM_BASE_A 25'h020000
`define ROM_BASE_B 25'h040000
`define ROM_BASE_C 25'h060000
`define ROM_BASE_D 25'h080000
`define ROM_SIZE   25'h010000
// Subtracted from loader address to get SDRAM address
`define ROM_OFS_A  25'h020000
`define ROM_OFS_B  25'h040000
`define ROM_OFS_C  25'h050000
`define ROM_OFS_D  25'h070000

// Loader indices
`define IDX_CONFIG 8'd1
`define IDX_DIP    8'd254
// Number of DIP switch bytes kept
`define DIP_BYTES  3

// Rotary wrap points
`define ROT_LEFT_END  8'h80
`define ROT_RIGHT_END 8'h01

`endif

//--- source/ctrl_pkg.sv
package ctrl_pkg;

	// ====================
	// Keyboard input
	// ====================
	// Event word from the PS/2 side
	// Toggle flips once per key event
	typedef struct packed {
		logic       toggle;
		// 1 on make, 0 on break
		logic       pressed;
		// E0 prefix seen
		logic       extended;
		logic [7:0] code;
	} ps2_key_t;

	// ====================
	// Arcade controls
	// ====================
	// One player's controls, active high
	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		// Machine gun
		logic shot;
		// Grenades and rockets
		logic missile;
		logic start;
		// Rotary step requests
		logic rotary_l;
		logic rotary_r;
	} player_ctrl_t;

	// Cabinet-wide controls, active high
	typedef struct packed {
		logic coin1;
		logic coin2;
		logic service;
		logic pause;
	} system_ctrl_t;

	// One-hot dial position
	// All ones means no rotary hardware
	typedef logic [7:0] rotary_pos_t;

endpackage

//--- source/loader_pkg.sv
package loader_pkg;

	// ====================
	// Loader bus
	// ====================
	// Byte-wide download stream from the host
	typedef struct packed {
		// High for the whole transfer
		logic        download;
		// One-cycle write strobe
		logic        wr;
		// Selects what is being loaded
		logic [7:0]  index;
		logic [24:0] addr;
		logic [7:0]  dout;
	} ioctl_bus_t;

	// ====================
	// SDRAM write port
	// ====================
	// Word write with byte lanes
	typedef struct packed {
		logic [23:0] addr;
		// Same byte in both halves
		logic [15:0] data;
		logic        lane_lo;
		logic        lane_hi;
	} rom_wr_req_t;

	// ====================
	// Board setup
	// ====================
	typedef struct packed {
		// 01 selects the bootleg board
		logic [1:0]  is_bootleg;
		logic        is_rotary;
		// Byte 0 in the low bits
		logic [23:0] dipsw;
	} core_config_t;

endpackage

//--- source/control_mapper.sv
`include "jackal_defines.svh"

module control_mapper (
	input  logic                  CLK_49M,
	input  logic                  rst_n,
	input  ctrl_pkg::ps2_key_t    ps2_key,
	input  logic [15:0]           joystick_0,
	input  logic [15:0]           joystick_1,
	output ctrl_pkg::player_ctrl_t p1_ctrl,
	output ctrl_pkg::player_ctrl_t p2_ctrl,
	output ctrl_pkg::system_ctrl_t sys_ctrl
);
	import ctrl_pkg::*;

	// Last seen toggle, a difference marks a new event
	logic         toggle_q;
	logic         key_event;

	// Keys shared by both players
	logic         kb_up;
	logic         kb_down;
	logic         kb_left;
	logic         kb_right;
	logic         kb_shot;
	logic         kb_missile;
	logic         kb_start1;
	logic         kb_start2;
	// Coin, service and pause keys
	system_ctrl_t kb_sys;

	assign key_event = toggle_q != ps2_key.toggle;

	// ====================
	// Key flags
	// ====================
	always_ff @(posedge CLK_49M) begin
		if (!rst_n) begin
			toggle_q   <= 1'b0;
			kb_up      <= 1'b0;
			kb_down    <= 1'b0;
			kb_left    <= 1'b0;
			kb_right   <= 1'b0;
			kb_shot    <= 1'b0;
			kb_missile <= 1'b0;
			kb_start1  <= 1'b0;
			kb_start2  <= 1'b0;
			kb_sys     <= '0;
		end else begin
			toggle_q <= ps2_key.toggle;
			if (key_event) begin
				// Make sets, break clears
				case (ps2_key.code)
					`KEY_1:     kb_start1      <= ps2_key.pressed;
					`KEY_2:     kb_start2      <= ps2_key.pressed;
					`KEY_5:     kb_sys.coin1   <= ps2_key.pressed;
					`KEY_6:     kb_sys.coin2   <= ps2_key.pressed;
					`KEY_9:     kb_sys.service <= ps2_key.pressed;
					`KEY_P:     kb_sys.pause   <= ps2_key.pressed;
					`KEY_UP:    kb_up          <= ps2_key.pressed;
					`KEY_DOWN:  kb_down        <= ps2_key.pressed;
					`KEY_LEFT:  kb_left        <= ps2_key.pressed;
					`KEY_RIGHT: kb_right       <= ps2_key.pressed;
					`KEY_CTRL:  kb_shot        <= ps2_key.pressed;
					`KEY_ALT:   kb_missile     <= ps2_key.pressed;
					default:    ;
				endcase
			end
		end
	end

	// ====================
	// Merge with joysticks
	// ====================
	// Joystick bits: 0 right, 1 left, 2 down, 3 up, 4 shot, 5 missile,
	// 6 rotary right, 7 rotary left, 8 start, 9 coin, 10 pause
	assign p1_ctrl = '{
		up:       kb_up      | joystick_0[3],
		down:     kb_down    | joystick_0[2],
		left:     kb_left    | joystick_0[1],
		right:    kb_right   | joystick_0[0],
		shot:     kb_shot    | joystick_0[4],
		missile:  kb_missile | joystick_0[5],
		start:    kb_start1  | joystick_0[8],
		rotary_l: joystick_0[7],
		rotary_r: joystick_0[6]
	};

	assign p2_ctrl = '{
		up:       kb_up      | joystick_1[3],
		down:     kb_down    | joystick_1[2],
		left:     kb_left    | joystick_1[1],
		right:    kb_right   | joystick_1[0],
		shot:     kb_shot    | joystick_1[4],
		missile:  kb_missile | joystick_1[5],
		start:    kb_start2  | joystick_1[8],
		rotary_l: joystick_1[7],
		rotary_r: joystick_1[6]
	};

	// Coin1 and pause from either stick, coin2 and service keyboard only
	assign sys_ctrl = '{
		coin1:   kb_sys.coin1 | joystick_0[9] | joystick_1[9],
		coin2:   kb_sys.coin2,
		service: kb_sys.service,
		pause:   kb_sys.pause | joystick_0[10] | joystick_1[10]
	};

endmodule

//--- source/rotary_dial.sv
`include "jackal_defines.svh"

module rotary_dial #(
	parameter int DIV_BITS = 23
) (
	input  logic                   CLK_49M,
	input  logic                   rst_n,
	input  logic                   rotary_fast,
	input  ctrl_pkg::player_ctrl_t p1_ctrl,
	input  ctrl_pkg::player_ctrl_t p2_ctrl,
	input  logic [1:0]             is_bootleg,
	output ctrl_pkg::rotary_pos_t  p1_rotary,
	output ctrl_pkg::rotary_pos_t  p2_rotary
);
	import ctrl_pkg::*;

	// Free-running step divider
	logic [DIV_BITS-1:0] div_q;
	logic                tick;
	logic                no_dial;
	rotary_pos_t         pos1_q;
	rotary_pos_t         pos2_q;

	// One step of the dial, left wins over right
	function automatic rotary_pos_t step_pos(
		input rotary_pos_t pos,
		input logic        go_l,
		input logic        go_r
	);
		rotary_pos_t nxt;
		nxt = pos;
		if (go_l)
			nxt = (pos == `ROT_LEFT_END) ? `ROT_RIGHT_END : rotary_pos_t'(pos << 1);
		else if (go_r)
			nxt = (pos == `ROT_RIGHT_END) ? `ROT_LEFT_END : rotary_pos_t'(pos >> 1);
		return nxt;
	endfunction

	// ====================
	// Step rate
	// ====================
	// Fast mode ignores the top divider bit, twice the rate
	assign tick = rotary_fast ? (div_q[DIV_BITS-2:0] == '0) : (div_q == '0);

	always_ff @(posedge CLK_49M) begin
		if (!rst_n) begin
			div_q  <= '0;
			pos1_q <= `ROT_RIGHT_END;
			pos2_q <= `ROT_RIGHT_END;
		end else begin
			div_q <= div_q + 1'b1;
			if (tick) begin
				pos1_q <= step_pos(pos1_q, p1_ctrl.rotary_l, p1_ctrl.rotary_r);
				pos2_q <= step_pos(pos2_q, p2_ctrl.rotary_l, p2_ctrl.rotary_r);
			end
		end
	end

	// ====================
	// Bootleg override
	// ====================
	// Bootleg boards have no dial, core sees every position at once
	assign no_dial   = is_bootleg == 2'b01;
	assign p1_rotary = no_dial ? 8'hFF : pos1_q;
	assign p2_rotary = no_dial ? 8'hFF : pos2_q;

endmodule

//--- source/rom_load_router.sv
`include "jackal_defines.svh"

module rom_load_router (
	input  logic                     CLK_49M,
	input  logic                     rst_n,
	input  loader_pkg::ioctl_bus_t   ioctl,
	input  logic                     sdram_ready,
	output loader_pkg::rom_wr_req_t  sdram_req,
	output logic                     sdram_valid,
	output logic                     ioctl_wait
);
	import loader_pkg::*;

	// Region hits
	logic        in_a;
	logic        in_b;
	logic        in_c;
	logic        in_d;
	logic        rom_wr;
	logic [24:0] rebased;
	// Request waiting for the SDRAM side
	logic        pending_q;
	rom_wr_req_t req_q;

	// ====================
	// Region decode
	// ====================
	assign in_a = (ioctl.addr >= `ROM_BASE_A) && (ioctl.addr < `ROM_BASE_A + `ROM_SIZE);
	assign in_b = (ioctl.addr >= `ROM_BASE_B) && (ioctl.addr < `ROM_BASE_B + `ROM_SIZE);
	assign in_c = (ioctl.addr >= `ROM_BASE_C) && (ioctl.addr < `ROM_BASE_C + `ROM_SIZE);
	assign in_d = (ioctl.addr >= `ROM_BASE_D) && (ioctl.addr < `ROM_BASE_D + `ROM_SIZE);

	// Qualified by download for all four regions
	assign rom_wr = ioctl.download && ioctl.wr && (in_a || in_b || in_c || in_d);

	// Move each region to its SDRAM home
	always_comb begin
		if (in_a)
			rebased = ioctl.addr - `ROM_OFS_A;
		else if (in_b)
			rebased = ioctl.addr - `ROM_OFS_B;
		else if (in_c)
			rebased = ioctl.addr - `ROM_OFS_C;
		else
			rebased = ioctl.addr - `ROM_OFS_D;
	end

	// ====================
	// Request handshake
	// ====================
	always_ff @(posedge CLK_49M) begin
		if (!rst_n) begin
			pending_q <= 1'b0;
		end else if (pending_q) begin
			// Drops on the accepting edge
			if (sdram_ready)
				pending_q <= 1'b0;
		end else if (rom_wr) begin
			pending_q <= 1'b1;
		end
	end

	// Payload loads only when idle so it stays put under back-pressure
	always_ff @(posedge CLK_49M) begin
		if (!pending_q && rom_wr) begin
			req_q.addr    <= rebased[23:0];
			req_q.data    <= {ioctl.dout, ioctl.dout};
			// A and C fill the high byte, B and D the low byte
			req_q.lane_hi <= in_a || in_c;
			req_q.lane_lo <= in_b || in_d;
		end
	end

	assign sdram_req   = req_q;
	assign sdram_valid = pending_q;
	// Loader stalls for as long as the request is open
	assign ioctl_wait  = pending_q;

endmodule

//--- source/core_config_regs.sv
`include "jackal_defines.svh"

module core_config_regs (
	input  logic                     CLK_49M,
	input  logic                     rst_n,
	input  loader_pkg::ioctl_bus_t   ioctl,
	output loader_pkg::core_config_t core_cfg
);
	import loader_pkg::*;

	logic         cfg_wr;
	logic         dip_wr;
	core_config_t cfg_q;

	// ====================
	// Write decode
	// ====================
	// Board type byte lives at address 0 of the config index
	assign cfg_wr = ioctl.wr && (ioctl.index == `IDX_CONFIG) && (ioctl.addr == '0);
	// Only the first DIP bytes are kept
	assign dip_wr = ioctl.wr && (ioctl.index == `IDX_DIP) && (ioctl.addr < `DIP_BYTES);

	always_ff @(posedge CLK_49M) begin
		if (!rst_n) begin
			cfg_q <= '0;
		end else begin
			if (cfg_wr) begin
				cfg_q.is_bootleg <= ioctl.dout[1:0];
				// Bit 4 flags a rotary-capable set
				cfg_q.is_rotary  <= ioctl.dout[4];
			end
			if (dip_wr) begin
				// Address picks the byte, 0 at the bottom
				cfg_q.dipsw[ioctl.addr[1:0]*8 +: 8] <= ioctl.dout;
			end
		end
	end

	assign core_cfg = cfg_q;

endmodule

//--- source/jackal_io_top.sv
module jackal_io_top #(
	parameter int ROTARY_DIV_BITS = 23
) (
	input  logic                     CLK_49M,
	input  logic                     rst_n,
	// Player inputs
	input  ctrl_pkg::ps2_key_t       ps2_key,
	input  logic [15:0]              joystick_0,
	input  logic [15:0]              joystick_1,
	input  logic                     rotary_fast,
	// Loader side
	input  loader_pkg::ioctl_bus_t   ioctl,
	input  logic                     sdram_ready,
	output ctrl_pkg::player_ctrl_t   p1_ctrl,
	output ctrl_pkg::player_ctrl_t   p2_ctrl,
	output ctrl_pkg::system_ctrl_t   sys_ctrl,
	output ctrl_pkg::rotary_pos_t    p1_rotary,
	output ctrl_pkg::rotary_pos_t    p2_rotary,
	output loader_pkg::rom_wr_req_t  sdram_req,
	output logic                     sdram_valid,
	output logic                     ioctl_wait,
	output loader_pkg::core_config_t core_cfg
);
	import ctrl_pkg::*;
	import loader_pkg::*;

	// Shared between the dial and the outside
	player_ctrl_t p1_w;
	player_ctrl_t p2_w;
	core_config_t cfg_w;

	// ====================
	// Controls
	// ====================
	control_mapper u_ctrl (
		.CLK_49M    (CLK_49M),
		.rst_n      (rst_n),
		.ps2_key    (ps2_key),
		.joystick_0 (joystick_0),
		.joystick_1 (joystick_1),
		.p1_ctrl    (p1_w),
		.p2_ctrl    (p2_w),
		.sys_ctrl   (sys_ctrl)
	);

	rotary_dial #(
		.DIV_BITS (ROTARY_DIV_BITS)
	) u_rot (
		.CLK_49M     (CLK_49M),
		.rst_n       (rst_n),
		.rotary_fast (rotary_fast),
		.p1_ctrl     (p1_w),
		.p2_ctrl     (p2_w),
		.is_bootleg  (cfg_w.is_bootleg),
		.p1_rotary   (p1_rotary),
		.p2_rotary   (p2_rotary)
	);

	// ====================
	// Loader
	// ====================
	rom_load_router u_rom (
		.CLK_49M     (CLK_49M),
		.rst_n       (rst_n),
		.ioctl       (ioctl),
		.sdram_ready (sdram_ready),
		.sdram_req   (sdram_req),
		.sdram_valid (sdram_valid),
		.ioctl_wait  (ioctl_wait)
	);

	core_config_regs u_cfg (
		.CLK_49M  (CLK_49M),
		.rst_n    (rst_n),
		.ioctl    (ioctl),
		.core_cfg (cfg_w)
	);

	assign p1_ctrl  = p1_w;
	assign p2_ctrl  = p2_w;
	assign core_cfg = cfg_w;

endmodule

//--- sim/jackal_io_props.sv
`include "jackal_defines.svh"

module jackal_io_props (
	input  logic                     CLK_49M,
	input  logic                     rst_n,
	input  ctrl_pkg::ps2_key_t       ps2_key,
	input  logic [15:0]              joystick_0,
	input  logic [15:0]              joystick_1,
	input  loader_pkg::ioctl_bus_t   ioctl,
	input  logic                     sdram_ready,
	input  ctrl_pkg::player_ctrl_t   p1_ctrl,
	input  ctrl_pkg::player_ctrl_t   p2_ctrl,
	input  ctrl_pkg::system_ctrl_t   sys_ctrl,
	input  ctrl_pkg::rotary_pos_t    p1_rotary,
	input  ctrl_pkg::rotary_pos_t    p2_rotary,
	input  loader_pkg::rom_wr_req_t  sdram_req,
	input  logic                     sdram_valid,
	input  logic                     ioctl_wait,
	input  loader_pkg::core_config_t core_cfg
);
	import ctrl_pkg::*;
	import loader_pkg::*;

	// Failed checks so far
	int           fail_count = 0;

	// Values seen at the previous edge
	ps2_key_t     prev_key;
	player_ctrl_t prev_p1;
	player_ctrl_t prev_p2;
	rotary_pos_t  prev_rot1;
	rotary_pos_t  prev_rot2;
	logic         prev_boot;
	ioctl_bus_t   prev_io;
	core_config_t prev_cfg;

	logic         boot;
	logic         rom_hit;
	rom_wr_req_t  exp_req;
	core_config_t exp_cfg;

	task automatic flag_error(input string msg);
		fail_count++;
		$error("%s", msg);
	endtask

	// Rotation of a one-hot dial including the wrap
	function automatic rotary_pos_t next_pos(input rotary_pos_t pos, input player_ctrl_t c);
		if (c.rotary_l)
			return {pos[6:0], pos[7]};
		if (c.rotary_r)
			return {pos[0], pos[7:1]};
		return pos;
	endfunction

	// 64 KiB regions at 0x2xxxx, 0x4xxxx, 0x6xxxx, 0x8xxxx
	function automatic logic in_rom(input logic [24:0] a);
		return a[24:16] inside {9'h002, 9'h004, 9'h006, 9'h008};
	endfunction

	function automatic logic [23:0] sdram_addr(input logic [24:0] a);
		logic [24:0] ofs;
		logic [24:0] r;
		case (a[24:16])
			9'h002:  ofs = `ROM_OFS_A;
			9'h004:  ofs = `ROM_OFS_B;
			9'h006:  ofs = `ROM_OFS_C;
			default: ofs = `ROM_OFS_D;
		endcase
		r = a - ofs;
		return r[23:0];
	endfunction

	// ====================
	// Reference model
	// ====================
	assign boot    = core_cfg.is_bootleg == 2'b01;
	assign rom_hit = ioctl.download && ioctl.wr && in_rom(ioctl.addr);

	always_ff @(posedge CLK_49M) begin
		prev_key  <= ps2_key;
		prev_p1   <= p1_ctrl;
		prev_p2   <= p2_ctrl;
		prev_rot1 <= p1_rotary;
		prev_rot2 <= p2_rotary;
		prev_boot <= boot;
		prev_io   <= ioctl;
		prev_cfg  <= core_cfg;
	end

	always_comb begin
		exp_req.addr    = sdram_addr(prev_io.addr);
		exp_req.data    = {prev_io.dout, prev_io.dout};
		// Regions A and C have address bit 17 set and take the high byte
		exp_req.lane_hi = prev_io.addr[17];
		exp_req.lane_lo = !prev_io.addr[17];
	end

	always_comb begin
		exp_cfg = prev_cfg;
		if (prev_io.wr && prev_io.index == `IDX_CONFIG && prev_io.addr == '0) begin
			exp_cfg.is_bootleg = prev_io.dout[1:0];
			exp_cfg.is_rotary  = prev_io.dout[4];
		end
		if (prev_io.wr && prev_io.index == `IDX_DIP && prev_io.addr < `DIP_BYTES) begin
			case (prev_io.addr[1:0])
				2'd0:    exp_cfg.dipsw[7:0]   = prev_io.dout;
				2'd1:    exp_cfg.dipsw[15:8]  = prev_io.dout;
				default: exp_cfg.dipsw[23:16] = prev_io.dout;
			endcase
		end
	end

	// ====================
	// Controls
	// ====================
	a_key_start: assert property (@(posedge CLK_49M) disable iff (!rst_n)
		(ps2_key.toggle != prev_key.toggle) && ps2_key.code == `KEY_1
		|=> p1_ctrl.start == (prev_key.pressed | joystick_0[8]))
		else flag_error($sformatf("error p1_ctrl.start %h expected %h",
			$sampled(p1_ctrl.start), $sampled(prev_key.pressed | joystick_0[8])));

	a_key_coin: assert property (@(posedge CLK_49M) disable iff (!rst_n)
		(ps2_key.toggle != prev_key.toggle) && ps2_key.code == `KEY_5
		|=> sys_ctrl.coin1 == (prev_key.pressed | joystick_0[9] | joystick_1[9]))
		else flag_error($sformatf("error sys_ctrl.coin1 %h expected %h",
			$sampled(sys_ctrl.coin1),
			$sampled(prev_key.pressed | joystick_0[9] | joystick_1[9])));

	a_p2_start_joy: assert property (@(posedge CLK_49M) disable iff (!rst_n)
		joystick_1[8] |-> p2_ctrl.start)
		else flag_error($sformatf("error p2_ctrl.start %h expected 1", $sampled(p2_ctrl.start)));

	// ====================
	// Rotary dials
	// ====================
	a_rot_onehot: assert property (@(posedge CLK_49M) disable iff (!rst_n)
		!boot |-> $onehot(p1_rotary) && $onehot(p2_rotary))
		else flag_error($sformatf("error p1_rotary %h p2_rotary %h not one-hot",
			$sampled(p1_rotary), $sampled(p2_rotary)));

	// Either unchanged or exactly one step in the requested direction
	a_rot_step: assert property (@(posedge CLK_49M) disable iff (!rst_n)
		!boot && !prev_boot |->
		(p1_rotary == prev_rot1 || p1_rotary == next_pos(prev_rot1, prev_p1)) &&
		(p2_rotary == prev_rot2 || p2_rotary == next_pos(prev_rot2, prev_p2)))
		else flag_error($sformatf("error p1_rotary %h p2_rotary %h from %h %h",
			$sampled(p1_rotary), $sampled(p2_rotary),
			$sampled(prev_rot1), $sampled(prev_rot2)));

	a_boot_ff: assert property (@(posedge CLK_49M) disable iff (!rst_n)
		boot |-> p1_rotary == 8'hFF && p2_rotary == 8'hFF)
		else flag_error($sformatf("error p1_rotary %h p2_rotary %h expected ff ff",
			$sampled(p1_rotary), $sampled(p2_rotary)));

	// ====================
	// SDRAM requests
	// ====================
	a_req_payload: assert property (@(posedge CLK_49M) disable iff (!rst_n)
		!sdram_valid && rom_hit |=> sdram_valid && sdram_req == exp_req)
		else flag_error($sformatf("error sdram_req %h sdram_valid %h expected %h 1",
			$sampled(sdram_req), $sampled(sdram_valid), $sampled(exp_req)));

	a_req_none: assert property (@(posedge CLK_49M) disable iff (!rst_n)
		!sdram_valid && !rom_hit |=> !sdram_valid)
		else flag_error($sformatf("error sdram_valid %h expected 0", $sampled(sdram_valid)));

	a_req_hold: assert property (@(posedge CLK_49M) disable iff (!rst_n)
		sdram_valid && !sdram_ready |=> sdram_valid && $stable(sdram_req))
		else flag_error($sformatf("error sdram_req %h sdram_valid %h under back-pressure",
			$sampled(sdram_req), $sampled(sdram_valid)));

	a_req_release: assert property (@(posedge CLK_49M) disable iff (!rst_n)
		sdram_valid && sdram_ready |=> !sdram_valid)
		else flag_error($sformatf("error sdram_valid %h expected 0", $sampled(sdram_valid)));

	a_wait_eq: assert property (@(posedge CLK_49M) disable iff (!rst_n)
		ioctl_wait == sdram_valid)
		else flag_error($sformatf("error ioctl_wait %h expected %h",
			$sampled(ioctl_wait), $sampled(sdram_valid)));

	// ====================
	// Board config
	// ====================
	a_cfg: assert property (@(posedge CLK_49M) disable iff (!rst_n)
		core_cfg == exp_cfg)
		else flag_error($sformatf("error core_cfg %h expected %h",
			$sampled(core_cfg), $sampled(exp_cfg)));

endmodule

bind jackal_io_top jackal_io_props u_props (.*);

//--- sim/tb_jackal_io.sv
`include "jackal_defines.svh"

module tb_jackal_io;
	import ctrl_pkg::*;
	import loader_pkg::*;

	// Whole run is about 1100 cycles at DIV_BITS 6
	localparam int MAX_CYCLES = 4000;

	logic         CLK_49M = 1'b0;
	logic         rst_n;
	ps2_key_t     ps2_key;
	logic [15:0]  joystick_0;
	logic [15:0]  joystick_1;
	logic         rotary_fast;
	ioctl_bus_t   ioctl;
	logic         sdram_ready;
	player_ctrl_t p1_ctrl;
	player_ctrl_t p2_ctrl;
	system_ctrl_t sys_ctrl;
	rotary_pos_t  p1_rotary;
	rotary_pos_t  p2_rotary;
	rom_wr_req_t  sdram_req;
	logic         sdram_valid;
	logic         ioctl_wait;
	core_config_t core_cfg;
	int           cycles = 0;
	int           seed = 42;

	jackal_io_top #(
		.ROTARY_DIV_BITS (6)
	) u_dut (.*);

	always #5 CLK_49M = ~CLK_49M;

	// ====================
	// Run guards
	// ====================
	always @(posedge CLK_49M) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("TB FAILED");
			$fatal(1, "Timeout, stimulus still running after %0d cycles", cycles);
		end
	end

	// Failures counted at the rising edge show up by the falling edge
	always @(negedge CLK_49M) begin
		if (u_dut.u_props.fail_count != 0) begin
			$display("TB FAILED");
			$fatal(1, "A bound assertion failed");
		end
	end

	// Inputs change just after the rising edge
	task automatic next_cycle();
		@(posedge CLK_49M);
		#1;
	endtask

	task automatic send_key(input logic [7:0] code, input logic pressed);
		ps2_key.code    = code;
		ps2_key.pressed = pressed;
		ps2_key.toggle  = ~ps2_key.toggle;
		repeat (3) next_cycle();
	endtask

	task automatic loader_write(input logic [7:0] index, input logic [24:0] addr,
		input logic [7:0] data);
		ioctl.index = index;
		ioctl.addr  = addr;
		ioctl.dout  = data;
		ioctl.wr    = 1'b1;
		next_cycle();
		ioctl.wr    = 1'b0;
		next_cycle();
	endtask

	// One download byte with ready held low for hold cycles once the request is up
	task automatic rom_write(input logic dl, input logic [24:0] addr,
		input logic [7:0] data, input int hold);
		ioctl.download = dl;
		ioctl.index    = 8'd0;
		ioctl.addr     = addr;
		ioctl.dout     = data;
		ioctl.wr       = 1'b1;
		sdram_ready    = (hold == 0);
		next_cycle();
		ioctl.wr       = 1'b0;
		if (sdram_valid) begin
			repeat (hold) begin
				// Stray write while pending must be ignored
				ioctl.addr = `ROM_BASE_B + 25'(hold);
				ioctl.wr   = (hold > 1);
				next_cycle();
				ioctl.wr   = 1'b0;
			end
			sdram_ready = 1'b1;
			while (sdram_valid)
				next_cycle();
		end
		sdram_ready    = 1'b0;
		ioctl.download = 1'b0;
		repeat (2) next_cycle();
	endtask

	// Waits for p1 dial to move n times
	task automatic wait_rot_steps(input int n);
		rotary_pos_t last;
		repeat (n) begin
			last = p1_rotary;
			while (p1_rotary == last)
				next_cycle();
		end
	endtask

	// ====================
	// Stimulus
	// ====================
	initial begin
		rst_n       = 1'b0;
		ps2_key     = '0;
		joystick_0  = '0;
		joystick_1  = '0;
		rotary_fast = 1'b0;
		ioctl       = '0;
		sdram_ready = 1'b0;
		repeat (3) @(posedge CLK_49M);
		#1;
		rst_n = 1'b1;
		next_cycle();

		// Start key then p2 start from the stick alone
		send_key(`KEY_1, 1'b1);
		send_key(`KEY_1, 1'b0);
		send_key(`KEY_5, 1'b1);
		send_key(`KEY_5, 1'b0);
		joystick_1[8] = 1'b1;
		next_cycle();
		joystick_1[8] = 1'b0;

		// Dials with p1 left and p2 right at fast then normal rate
		rotary_fast   = 1'b1;
		joystick_0[7] = 1'b1;
		joystick_1[6] = 1'b1;
		wait_rot_steps(10);
		rotary_fast = 1'b0;
		wait_rot_steps(2);
		// Reverse directions
		rotary_fast   = 1'b1;
		joystick_0[7] = 1'b0;
		joystick_0[6] = 1'b1;
		joystick_1[6] = 1'b0;
		joystick_1[7] = 1'b1;
		wait_rot_steps(10);
		// Both pressed so left wins
		joystick_0[7] = 1'b1;
		wait_rot_steps(2);

		// Bootleg forces all ones before going back to a dial board
		loader_write(`IDX_CONFIG, 25'd0, 8'h01);
		repeat (40) next_cycle();
		loader_write(`IDX_CONFIG, 25'd1, 8'h00);
		loader_write(`IDX_CONFIG, 25'd0, 8'h10);
		wait_rot_steps(2);
		joystick_0 = '0;
		joystick_1 = '0;

		// ROM routing and back-pressure
		rom_write(1'b1, 25'h060005, 8'hA7, 0);
		rom_write(1'b1, 25'h080003, 8'($random(seed)), 3);
		rom_write(1'b1, 25'h030000, 8'h55, 0);
		rom_write(1'b0, 25'h020010, 8'h66, 0);
		repeat (6) begin
			rom_write(1'b1, {4'd0, 3'($random(seed)), 1'b0, 17'($random(seed))} & 25'h0EFFFF
				| 25'h020000, 8'($random(seed)), $unsigned($random(seed)) % 4);
		end

		// DIP bytes with address 3 outside the kept range
		loader_write(`IDX_DIP, 25'd0, 8'($random(seed)));
		loader_write(`IDX_DIP, 25'd1, 8'($random(seed)));
		loader_write(`IDX_DIP, 25'd2, 8'($random(seed)));
		loader_write(`IDX_DIP, 25'd3, 8'($random(seed)));
		repeat (4) next_cycle();

		if (u_dut.u_props.fail_count == 0) begin
			$display("TB PASSED");
			$finish;
		end else begin
			$display("TB FAILED");
			$fatal(1, "Bound assertions reported failures");
		end
	end

endmodule

//--- flist.f
+incdir+source
source/ctrl_pkg.sv
source/loader_pkg.sv
source/control_mapper.sv
source/rotary_dial.sv
source/rom_load_router.sv
source/core_config_regs.sv
source/jackal_io_top.sv
sim/jackal_io_props.sv
sim/tb_jackal_io.sv
